//--- source/spi_params.svh
`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

// Bits per transfer
`define SPI_DATA_WIDTH 16

// clk cycles per SCK half period
`define SPI_HALF_PERIOD 4

// Bit counter must hold the value SPI_DATA_WIDTH
`define SPI_BIT_COUNT_WIDTH 5

`endif

//--- source/spi_pkg.sv
`default_nettype none

`include "spi_params.svh"

package spi_pkg;

  typedef logic [`SPI_DATA_WIDTH-1:0] spi_word_t;

  // Shift engine states
  typedef enum logic [1:0] {
    SPI_IDLE  = 2'd0,
    SPI_SHIFT = 2'd1,
    SPI_DONE  = 2'd2
  } spi_state_e;

endpackage

`default_nettype wire

//--- source/spi_start_stage.sv
`default_nettype none

module spi_start_stage
  import spi_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      en,
  input  logic      start,
  input  spi_word_t data_in,
  input  logic      engine_idle,
  output logic      launch,
  output spi_word_t tx_word
);

  // Last two samples of start, newest in bit 0
  logic [1:0] start_hist;
  logic       start_edge;
  logic       accept;

  assign start_edge = (start_hist == 2'b01);

  // Edges seen while disabled or busy are simply lost
  assign accept = start_edge && en && engine_idle;

  always_ff @(posedge clk) begin
    if (reset) begin
      start_hist <= 2'b00;
    end else begin
      start_hist <= {start_hist[0], start};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      launch <= 1'b0;
    end else begin
      launch <= accept;
    end
  end

  // Word is captured together with the launch pulse
  always_ff @(posedge clk) begin
    if (accept) begin
      tx_word <= data_in;
    end
  end

endmodule

`default_nettype wire

//--- source/spi_sck_gen.sv
`default_nettype none

`include "spi_params.svh"

module spi_sck_gen (
  input  logic clk,
  input  logic reset,
  input  logic sck_run,
  output logic sck,
  output logic sck_rise,
  output logic sck_fall
);

  localparam int unsigned HALF_PERIOD = `SPI_HALF_PERIOD;
  localparam int unsigned CNT_W = (HALF_PERIOD > 1) ? $clog2(HALF_PERIOD) : 1;

  logic [CNT_W-1:0] half_cnt;
  logic             toggle;

  // Flip sck at the end of every half period
  assign toggle = sck_run && (half_cnt == CNT_W'(HALF_PERIOD - 1));

  always_ff @(posedge clk) begin
    if (reset || !sck_run) begin
      half_cnt <= '0;
    end else if (toggle) begin
      half_cnt <= '0;
    end else begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

  // Strobes line up with the cycle in which sck shows its new level
  always_ff @(posedge clk) begin
    if (reset || !sck_run) begin
      sck      <= 1'b0;
      sck_rise <= 1'b0;
      sck_fall <= 1'b0;
    end else begin
      sck_rise <= toggle && !sck;
      sck_fall <= toggle && sck;
      if (toggle) begin
        sck <= ~sck;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/spi_shift_engine.sv
`default_nettype none

`include "spi_params.svh"

module spi_shift_engine
  import spi_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      en,
  input  logic      launch,
  input  spi_word_t tx_word,
  input  logic      miso,
  input  logic      sck_rise,
  input  logic      sck_fall,
  output logic      sck_run,
  output logic      sel,
  output logic      busy,
  output logic      engine_idle,
  output logic      mosi,
  output logic      done,
  output spi_word_t rx_word,
  output logic      launch_seen
);

  localparam int unsigned DATA_WIDTH = `SPI_DATA_WIDTH;
  localparam int unsigned CNT_W = `SPI_BIT_COUNT_WIDTH;

  spi_state_e       state;
  spi_state_e       state_next;
  logic [CNT_W-1:0] bit_cnt;
  spi_word_t        tx_shift;
  spi_word_t        rx_shift;
  logic             miso_q;
  logic             shifting;
  logic             accept;
  logic             last_fall;

  assign shifting = (state == SPI_SHIFT);
  assign accept = (state == SPI_IDLE) && launch && en;

  // Fall after the last rise ends the word
  assign last_fall = shifting && sck_fall && (bit_cnt == CNT_W'(DATA_WIDTH));

  always_comb begin
    state_next = state;
    case (state)
      SPI_IDLE: begin
        if (accept) begin
          state_next = SPI_SHIFT;
        end
      end
      SPI_SHIFT: begin
        if (last_fall) begin
          state_next = SPI_DONE;
        end
      end
      SPI_DONE: begin
        state_next = SPI_IDLE;
      end
      default: begin
        state_next = SPI_IDLE;
      end
    endcase
    // Dropping en aborts from any state
    if (!en) begin
      state_next = SPI_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= SPI_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Counts sck rises within the current word
  always_ff @(posedge clk) begin
    if (reset || !shifting) begin
      bit_cnt <= '0;
    end else if (sck_rise) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // Single sampling register on the incoming line
  always_ff @(posedge clk) begin
    miso_q <= miso;
  end

  // Transmit LSB first, next bit appears after each fall
  always_ff @(posedge clk) begin
    if (accept) begin
      tx_shift <= tx_word;
    end else if (shifting && sck_fall) begin
      tx_shift <= {1'b0, tx_shift[DATA_WIDTH-1:1]};
    end
  end

  // Receive MSB first
  always_ff @(posedge clk) begin
    if (shifting && sck_rise) begin
      rx_shift <= {rx_shift[DATA_WIDTH-2:0], miso_q};
    end
  end

  assign sck_run     = shifting;
  assign sel         = shifting;
  assign busy        = shifting;
  assign engine_idle = (state == SPI_IDLE);
  assign mosi        = tx_shift[0] && shifting;
  assign done        = (state == SPI_DONE);
  assign rx_word     = rx_shift;
  assign launch_seen = accept;

endmodule

`default_nettype wire

//--- source/spi_result_stage.sv
`default_nettype none

module spi_result_stage
  import spi_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      en,
  input  logic      done,
  input  logic      launch_seen,
  input  spi_word_t rx_word,
  output logic      valid,
  output spi_word_t data_out
);

  spi_word_t rx_hold;

  // valid is held until a new transfer starts or en drops
  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= 1'b0;
    end else if (!en) begin
      valid <= 1'b0;
    end else if (launch_seen) begin
      valid <= 1'b0;
    end else if (done) begin
      valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (done) begin
      rx_hold <= rx_word;
    end
  end

  // Output reads as zero without a valid word
  assign data_out = valid ? rx_hold : '0;

endmodule

`default_nettype wire

//--- source/spi_master_top.sv
`default_nettype none

module spi_master_top
  import spi_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      en,
  input  logic      start,
  input  spi_word_t data_in,
  input  logic      miso,
  output logic      sck,
  output logic      mosi,
  output logic      sel,
  output logic      busy,
  output logic      valid,
  output spi_word_t data_out
);

  logic      launch;
  spi_word_t tx_word;
  logic      engine_idle;
  logic      sck_run;
  logic      sck_rise;
  logic      sck_fall;
  logic      done;
  spi_word_t rx_word;
  logic      launch_seen;

  spi_start_stage i_start_stage (
    .clk         (clk),
    .reset       (reset),
    .en          (en),
    .start       (start),
    .data_in     (data_in),
    .engine_idle (engine_idle),
    .launch      (launch),
    .tx_word     (tx_word)
  );

  spi_sck_gen i_sck_gen (
    .clk      (clk),
    .reset    (reset),
    .sck_run  (sck_run),
    .sck      (sck),
    .sck_rise (sck_rise),
    .sck_fall (sck_fall)
  );

  spi_shift_engine i_shift_engine (
    .clk         (clk),
    .reset       (reset),
    .en          (en),
    .launch      (launch),
    .tx_word     (tx_word),
    .miso        (miso),
    .sck_rise    (sck_rise),
    .sck_fall    (sck_fall),
    .sck_run     (sck_run),
    .sel         (sel),
    .busy        (busy),
    .engine_idle (engine_idle),
    .mosi        (mosi),
    .done        (done),
    .rx_word     (rx_word),
    .launch_seen (launch_seen)
  );

  spi_result_stage i_result_stage (
    .clk         (clk),
    .reset       (reset),
    .en          (en),
    .done        (done),
    .launch_seen (launch_seen),
    .rx_word     (rx_word),
    .valid       (valid),
    .data_out    (data_out)
  );

endmodule

`default_nettype wire

//--- verif/spi_master_asserts.sv
`default_nettype none

module spi_master_asserts
  import spi_pkg::*;
(
  input logic      clk,
  input logic      reset,
  input logic      en,
  input logic      sck,
  input logic      sel,
  input logic      busy,
  input logic      valid,
  input spi_word_t data_out
);

  timeunit 1ns;
  timeprecision 1ps;

  // Number of assertion failures so far
  int unsigned fail_count = 0;

  // An abort lets sck trail sel by one cycle while en is low
  property sck_parked_without_sel;
    @(posedge clk) disable iff (reset || !en)
      !sel |-> !sck;
  endproperty

  property data_zero_without_valid;
    @(posedge clk) disable iff (reset)
      !valid |-> (data_out == '0);
  endproperty

  // valid drops on launch, the same edge busy rises
  property valid_busy_exclusive;
    @(posedge clk) disable iff (reset)
      !(valid && busy);
  endproperty

  a_sck_parked: assert property (sck_parked_without_sel)
    else begin
      $error("sck is high while sel is low");
      fail_count++;
    end

  a_data_zero: assert property (data_zero_without_valid)
    else begin
      $error("data_out is nonzero while valid is low");
      fail_count++;
    end

  a_valid_busy: assert property (valid_busy_exclusive)
    else begin
      $error("valid and busy are high together");
      fail_count++;
    end

endmodule

bind spi_master_top spi_master_asserts i_spi_master_asserts (
  .clk      (clk),
  .reset    (reset),
  .en       (en),
  .sck      (sck),
  .sel      (sel),
  .busy     (busy),
  .valid    (valid),
  .data_out (data_out)
);

`default_nettype wire

//--- verif/spi_master_tb.sv
`default_nettype none

`include "spi_params.svh"

module spi_master_tb
  import spi_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DW = `SPI_DATA_WIDTH;
  localparam int HP = `SPI_HALF_PERIOD;
  localparam int STEP_TIMEOUT = 4 * HP * DW;
  localparam int CYCLES_PER_LINE = 4 * HP * DW + 50;
  localparam int MAX_LINES = 32;
  localparam int FIELDS = 5;

  // Operation codes in the stimulus file
  localparam int OP_NORMAL = 1;
  localparam int OP_DOUBLE = 2;
  localparam int OP_ABORT = 3;

  logic      clk;
  logic      reset;
  logic      en;
  logic      start;
  spi_word_t data_in;
  logic      miso;
  logic      sck;
  logic      mosi;
  logic      sel;
  logic      busy;
  logic      valid;
  spi_word_t data_out;

  logic [31:0] stim_mem [0:FIELDS*MAX_LINES-1];
  int          line_count = 0;
  int          errors = 0;
  int          tests = 0;
  int          passed = 0;
  int          assert_fails = 0;

  // Slave model and bus monitor state
  spi_word_t slave_resp;
  spi_word_t cap_word;
  logic      miso_next;
  int        bit_idx;
  int        rise_count;
  int        valid_rises = 0;
  logic      sel_q;
  logic      sck_q;
  logic      valid_q;

  spi_master_top i_spi_master_top (
    .clk      (clk),
    .reset    (reset),
    .en       (en),
    .start    (start),
    .data_in  (data_in),
    .miso     (miso),
    .sck      (sck),
    .mosi     (mosi),
    .sel      (sel),
    .busy     (busy),
    .valid    (valid),
    .data_out (data_out)
  );

  always #5 clk = ~clk;

  // Monitor samples mid cycle, where every DUT output is settled
  always @(negedge clk) begin
    if (reset) begin
      sel_q = 1'b0;
      sck_q = 1'b0;
      valid_q = 1'b0;
    end else begin
      if (sel && !sel_q) begin
        rise_count = 0;
        cap_word = '0;
        bit_idx = DW - 1;
        miso_next = slave_resp[DW-1];
      end
      // mosi arrives LSB first
      if (sel && sck && !sck_q) begin
        rise_count++;
        cap_word = {mosi, cap_word[DW-1:1]};
      end
      if (sel && !sck && sck_q && bit_idx > 0) begin
        bit_idx--;
        miso_next = slave_resp[bit_idx];
      end
      if (valid && !valid_q) begin
        valid_rises++;
      end
      assert (!en || sel || !sck) else begin
        $display("sck was high while sel was low at %0t ns", $time);
        errors++;
      end
      sel_q = sel;
      sck_q = sck;
      valid_q = valid;
    end
  end

  // Slave drives miso just after the edge
  always @(posedge clk) begin
    #1;
    miso = miso_next;
  end

  initial begin
    wait (line_count > 0);
    repeat (line_count * CYCLES_PER_LINE) @(posedge clk);
    $display("Watchdog expired before all transfers finished");
    $display(">>> FAIL");
    $finish;
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  // Bound protocol assertion failures add to the error count
  task automatic collect_assert_fails();
    int fails;
    fails = i_spi_master_top.i_spi_master_asserts.fail_count;
    errors += fails - assert_fails;
    assert_fails = fails;
  endtask

  task automatic wait_busy(output bit ok);
    int n;
    ok = 1'b0;
    n = 0;
    while (!ok && n < STEP_TIMEOUT) begin
      step();
      ok = busy;
      n++;
    end
    assert (ok) else begin
      $display("Timed out waiting for busy to rise after start");
      errors++;
    end
  endtask

  task automatic wait_valid(output bit ok);
    int n;
    ok = 1'b0;
    n = 0;
    while (!ok && n < STEP_TIMEOUT) begin
      step();
      ok = valid;
      n++;
    end
    assert (ok) else begin
      $display("Timed out waiting for valid to rise after a transfer");
      errors++;
    end
  endtask

  task automatic launch_transfer(input spi_word_t tx, input spi_word_t resp, output bit ok);
    slave_resp = resp;
    data_in = tx;
    start = 1'b1;
    wait_busy(ok);
    start = 1'b0;
  endtask

  // Result must sit unchanged until the next start
  task automatic hold_result(input int gap, input spi_word_t resp);
    repeat (gap) begin
      step();
      check_value("valid", valid, 32'd1);
      check_value("data_out", data_out, resp);
    end
  endtask

  task automatic check_transfer(input spi_word_t tx, input spi_word_t resp);
    check_value("mosi word", cap_word, tx);
    check_value("sck rises", rise_count, DW);
    check_value("data_out", data_out, resp);
  endtask

  task automatic run_normal(input spi_word_t tx, input spi_word_t resp, input int gap);
    int  base;
    bit  ok;
    base = valid_rises;
    launch_transfer(tx, resp, ok);
    if (ok) begin
      wait_valid(ok);
    end
    if (ok) begin
      check_transfer(tx, resp);
      hold_result(gap, resp);
      check_value("valid rises", valid_rises - base, 32'd1);
    end
  endtask

  task automatic run_double(input spi_word_t tx, input spi_word_t resp, input int gap);
    int  base;
    bit  ok;
    base = valid_rises;
    launch_transfer(tx, resp, ok);
    if (ok) begin
      // Second edge with another word, while the engine is busy
      step();
      start = 1'b1;
      data_in = ~tx;
      wait_valid(ok);
    end
    start = 1'b0;
    if (ok) begin
      check_transfer(tx, resp);
      hold_result(gap, resp);
      check_value("valid rises", valid_rises - base, 32'd1);
    end
  endtask

  task automatic run_abort(input spi_word_t tx, input spi_word_t resp, input int gap,
                           input int offset);
    int  base;
    bit  ok;
    base = valid_rises;
    launch_transfer(tx, resp, ok);
    if (ok) begin
      repeat (offset) step();
      en = 1'b0;
      step();
      step();
      check_value("sel", sel, 32'd0);
      check_value("busy", busy, 32'd0);
      check_value("sck", sck, 32'd0);
      check_value("valid", valid, 32'd0);
      step();
      step();
      en = 1'b1;
      // Wait longer than the rest of the transfer would have taken
      repeat (gap + 2 * HP * DW) begin
        step();
        check_value("valid", valid, 32'd0);
      end
      check_value("valid rises", valid_rises - base, 32'd0);
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    collect_assert_fails();
    tests++;
    if (errors == errs_before) begin
      passed++;
      $display("test %0d (%s) passed", tests, name);
    end else begin
      $display("test %0d (%s) failed with %0d errors", tests, name, errors - errs_before);
    end
  endtask

  initial begin
    int        count;
    int        i;
    int        op;
    int        gap;
    int        offset;
    int        errs_before;
    spi_word_t tx;
    spi_word_t resp;
    string     name;

    clk = 1'b0;
    reset = 1'b1;
    en = 1'b0;
    start = 1'b0;
    data_in = '0;
    miso = 1'b0;
    miso_next = 1'b0;
    slave_resp = '0;
    cap_word = '0;
    bit_idx = 0;
    rise_count = 0;

    for (i = 0; i < FIELDS * MAX_LINES; i++) begin
      stim_mem[i] = '0;
    end
    $readmemh("verif/spi_stim.txt", stim_mem);
    count = 0;
    while (count < MAX_LINES && stim_mem[FIELDS*count] != 0) begin
      count++;
    end
    if (count == 0) begin
      $display("No transfers found in the stimulus file");
      errors++;
    end
    line_count = count;

    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    en = 1'b1;

    // Idle outputs before any start
    errs_before = errors;
    step();
    check_value("sck", sck, 32'd0);
    check_value("sel", sel, 32'd0);
    check_value("busy", busy, 32'd0);
    check_value("valid", valid, 32'd0);
    check_value("mosi", mosi, 32'd0);
    check_value("data_out", data_out, 32'd0);
    finish_test("reset state", errs_before);

    for (i = 0; i < count; i++) begin
      op = stim_mem[FIELDS*i];
      gap = stim_mem[FIELDS*i+1];
      tx = stim_mem[FIELDS*i+2][DW-1:0];
      resp = stim_mem[FIELDS*i+3][DW-1:0];
      offset = stim_mem[FIELDS*i+4];
      errs_before = errors;
      case (op)
        OP_NORMAL: begin
          name = "normal";
          run_normal(tx, resp, gap);
        end
        OP_DOUBLE: begin
          name = "double start";
          run_double(tx, resp, gap);
        end
        OP_ABORT: begin
          name = "abort";
          run_abort(tx, resp, gap, offset);
        end
        default: begin
          name = "unknown";
          $display("Unknown operation code %0d on stimulus line %0d", op, i);
          errors++;
        end
      endcase
      finish_test(name, errs_before);
    end

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             tests, passed, tests - passed, errors);
    if (errors == 0 && passed == tests) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/spi_stim.txt
// op gap tx_word resp_word abort_offset (all hex)
// op 1 normal, 2 double start, 3 abort, a line of zeros ends the list
1 08 a5c3 3c5a 0
1 04 0000 ffff 0
1 04 ffff 0000 0
1 06 0001 8000 0
1 06 8000 0001 0
1 05 1234 fedc 0
2 08 beef cafe 0
1 04 5a5a a5a5 0
3 0a 7e81 1111 05
1 06 0f0f f0f0 0
3 0a 2468 9bdf 40
1 05 dead b00c 0
2 06 c001 d00d 0
3 08 3579 8642 78
1 07 6b2d 94d2 0
0 0 0 0 0

//--- verilog.f
+incdir+source
source/spi_pkg.sv
source/spi_start_stage.sv
source/spi_sck_gen.sv
source/spi_shift_engine.sv
source/spi_result_stage.sv
source/spi_master_top.sv
verif/spi_master_asserts.sv
verif/spi_master_tb.sv

//--- Bender.yml
package:
  name: spi_master

sources:
  - include_dirs:
      - source
    files:
      - source/spi_pkg.sv
      - source/spi_start_stage.sv
      - source/spi_sck_gen.sv
      - source/spi_shift_engine.sv
      - source/spi_result_stage.sv
      - source/spi_master_top.sv

  - target: test
    include_dirs:
      - source
    files:
      - verif/spi_master_asserts.sv
      - verif/spi_master_tb.sv
